//--- source/kmeans_pkg.sv
package kmeans_pkg;

	// one coordinate, unsigned
	localparam int COORD_W = 8;

	// points are 3-D
	localparam int DIM = 3;

	// per-center point counter, covers the largest point set
	localparam int COUNT_W = 12;

	// a coordinate sum can hold 2**COUNT_W full-scale coordinates
	localparam int ACC_W = COORD_W + COUNT_W;

	typedef logic [COORD_W-1:0] coord_t;

	// index 0 is x in the low bits, then y, then z
	typedef coord_t [DIM-1:0] point_t;

	typedef logic [ACC_W-1:0] acc_t;

	typedef logic [COUNT_W-1:0] count_t;

	// single-cycle command requests
	typedef enum logic [1:0] {
		op_nop,
		op_load_center,
		op_divide,
		op_new_iteration
	} op_e;

	// iteration controller
	typedef enum logic [1:0] {
		st_idle,
		st_drain,
		st_divide,
		st_update
	} ctrl_state_e;

endpackage

//--- source/centroid_if.sv
`timescale 1ns/100ps

// sums and count of one center, picked by the divider
interface centroid_if #(
	parameter int NUM_CENTERS = 4,
	localparam int IDX_W = (NUM_CENTERS > 1) ? $clog2(NUM_CENTERS) : 1
);
	import kmeans_pkg::*;

	// center being divided
	logic [IDX_W-1:0] sel_index;

	// accumulated coordinates of that center
	acc_t sum_x;
	acc_t sum_y;
	acc_t sum_z;

	// points assigned to it
	count_t count;

	modport acc (input sel_index, output sum_x, output sum_y, output sum_z, output count);

	modport div (output sel_index, input sum_x, input sum_y, input sum_z, input count);

endinterface

//--- source/point_buffer.sv
`timescale 1ns/100ps

module point_buffer #(
	parameter int CREDITS = 4,
	localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1,
	localparam int CNT_W = $clog2(CREDITS + 1)
) (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  kmeans_pkg::point_t in_point,
	input  logic pop,
	output logic out_valid,
	output kmeans_pkg::point_t out_point,
	output logic empty,
	output logic credit
);
	import kmeans_pkg::*;

	point_t mem [CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic push;
	logic do_pop;

	// wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(CREDITS - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (fill == '0);
	assign do_pop = pop && !empty;

	// full never coincides with in_valid while the source honours its credits
	assign push = in_valid && (fill != CNT_W'(CREDITS));

	// popped point goes straight to the distance pipeline
	assign out_valid = do_pop;
	assign out_point = mem[rd_ptr];

	// one slot freed, one credit back
	assign credit = do_pop;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, do_pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_point;
	end

endmodule

//--- source/nearest_center.sv
`timescale 1ns/100ps

module nearest_center #(
	parameter int NUM_CENTERS = 4,
	localparam int IDX_W = (NUM_CENTERS > 1) ? $clog2(NUM_CENTERS) : 1
) (
	input  logic clk,
	input  logic rst,
	input  logic in_valid,
	input  kmeans_pkg::point_t in_point,
	input  kmeans_pkg::point_t centers [NUM_CENTERS],
	output logic out_valid,
	output logic [IDX_W-1:0] out_index,
	output kmeans_pkg::point_t out_point,
	output logic idle
);
	import kmeans_pkg::*;

	// three squared 8-bit differences
	localparam int DIST_W = 2 * COORD_W + 2;

	logic s1_valid;
	point_t s1_point;
	logic [DIST_W-1:0] s1_dist [NUM_CENTERS];
	logic [IDX_W-1:0] best_idx;
	logic [DIST_W-1:0] best_dist;

	// squared euclidean distance
	function automatic logic [DIST_W-1:0] sq_dist(point_t a, point_t b);
		logic [DIST_W-1:0] total;
		coord_t diff;
		total = '0;
		for (int d = 0; d < DIM; d++) begin
			diff = (a[d] > b[d]) ? a[d] - b[d] : b[d] - a[d];
			total = total + DIST_W'(diff) * DIST_W'(diff);
		end
		return total;
	endfunction

	// stage one, distance to every center
	always_ff @(posedge clk) begin
		s1_point <= in_point;
		for (int i = 0; i < NUM_CENTERS; i++)
			s1_dist[i] <= sq_dist(in_point, centers[i]);
	end

	// minimum search, strict compare so a tie stays on the lower index
	always_comb begin
		best_idx = '0;
		best_dist = s1_dist[0];
		for (int i = 1; i < NUM_CENTERS; i++) begin
			if (s1_dist[i] < best_dist) begin
				best_idx = IDX_W'(i);
				best_dist = s1_dist[i];
			end
		end
	end

	// stage two, winner and its point
	always_ff @(posedge clk) begin
		out_index <= best_idx;
		out_point <= s1_point;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			out_valid <= s1_valid;
		end
	end

	// nothing left in flight
	assign idle = !s1_valid && !out_valid;

endmodule

//--- source/centroid_accumulator.sv
`timescale 1ns/100ps

module centroid_accumulator #(
	parameter int NUM_CENTERS = 4,
	localparam int IDX_W = (NUM_CENTERS > 1) ? $clog2(NUM_CENTERS) : 1
) (
	input  logic clk,
	input  logic rst,
	input  logic add_valid,
	input  logic [IDX_W-1:0] add_index,
	input  kmeans_pkg::point_t add_point,
	input  logic clear_acc,
	centroid_if.acc rd
);
	import kmeans_pkg::*;

	// coordinate sums, second index is the coordinate
	acc_t sums [NUM_CENTERS][DIM];

	// points per center
	count_t counts [NUM_CENTERS];

	always_ff @(posedge clk) begin
		if (rst || clear_acc) begin
			// new iteration starts from empty clusters
			for (int i = 0; i < NUM_CENTERS; i++) begin
				counts[i] <= '0;
				for (int d = 0; d < DIM; d++)
					sums[i][d] <= '0;
			end
		end else if (add_valid) begin
			counts[add_index] <= counts[add_index] + 1'b1;
			for (int d = 0; d < DIM; d++)
				sums[add_index][d] <= sums[add_index][d] + ACC_W'(add_point[d]);
		end
	end

	// read side for the divider
	assign rd.sum_x = sums[rd.sel_index][0];
	assign rd.sum_y = sums[rd.sel_index][1];
	assign rd.sum_z = sums[rd.sel_index][2];
	assign rd.count = counts[rd.sel_index];

endmodule

//--- source/centroid_divider.sv
`timescale 1ns/100ps

module centroid_divider #(
	parameter int NUM_CENTERS = 4,
	localparam int IDX_W = (NUM_CENTERS > 1) ? $clog2(NUM_CENTERS) : 1
) (
	input  logic clk,
	input  logic rst,
	input  logic div_start,
	centroid_if.div rd,
	input  kmeans_pkg::point_t old_centers [NUM_CENTERS],
	output logic mean_valid,
	output logic [IDX_W-1:0] mean_index,
	output kmeans_pkg::point_t mean,
	output logic div_done
);
	import kmeans_pkg::*;

	localparam int DIM_W = $clog2(DIM);
	localparam int STEP_W = $clog2(ACC_W);

	typedef enum logic [2:0] {d_idle, d_load, d_shift, d_emit, d_done} div_state_e;

	div_state_e state;
	logic [IDX_W-1:0] center_idx;
	logic [DIM_W-1:0] coord_idx;
	logic [STEP_W-1:0] step;
	acc_t quo;
	count_t rem;
	point_t mean_reg;
	acc_t numer;
	logic [COUNT_W:0] rem_shift;
	logic fits;
	acc_t quo_next;
	count_t rem_next;

	assign rd.sel_index = center_idx;

	// dividend of the current coordinate
	always_comb begin
		case (coord_idx)
			DIM_W'(0): numer = rd.sum_x;
			DIM_W'(1): numer = rd.sum_y;
			default: numer = rd.sum_z;
		endcase
	end

	// one restoring step, quotient bit enters at the bottom
	always_comb begin
		rem_shift = {rem, quo[ACC_W-1]};
		fits = (rem_shift >= {1'b0, rd.count});
		quo_next = {quo[ACC_W-2:0], fits};
		rem_next = fits ? COUNT_W'(rem_shift - {1'b0, rd.count}) : rem_shift[COUNT_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= d_idle;
			center_idx <= '0;
			coord_idx <= '0;
		end else begin
			case (state)
				d_idle: begin
					if (div_start) begin
						center_idx <= '0;
						coord_idx <= '0;
						state <= d_load;
					end
				end
				// empty cluster skips all three divisions
				d_load: state <= (rd.count == '0) ? d_emit : d_shift;
				d_shift: begin
					if (step == STEP_W'(ACC_W - 1)) begin
						if (coord_idx == DIM_W'(DIM - 1)) begin
							coord_idx <= '0;
							state <= d_emit;
						end else begin
							coord_idx <= coord_idx + 1'b1;
							state <= d_load;
						end
					end
				end
				d_emit: begin
					if (center_idx == IDX_W'(NUM_CENTERS - 1)) begin
						state <= d_done;
					end else begin
						center_idx <= center_idx + 1'b1;
						state <= d_load;
					end
				end
				default: state <= d_idle;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		case (state)
			d_load: begin
				quo <= numer;
				rem <= '0;
				step <= '0;
				// no points, the center stays where it was
				if (rd.count == '0)
					mean_reg <= old_centers[center_idx];
			end
			d_shift: begin
				quo <= quo_next;
				rem <= rem_next;
				step <= step + 1'b1;
				// floor mean never exceeds a coordinate
				if (step == STEP_W'(ACC_W - 1))
					mean_reg[coord_idx] <= quo_next[COORD_W-1:0];
			end
			default: ;
		endcase
	end

	assign mean_valid = (state == d_emit);
	assign mean_index = center_idx;
	assign mean = mean_reg;
	assign div_done = (state == d_done);

endmodule

//--- source/iteration_control.sv
`timescale 1ns/100ps

module iteration_control #(
	parameter int NUM_CENTERS = 4,
	parameter int THRESHOLD = 2,
	localparam int IDX_W = (NUM_CENTERS > 1) ? $clog2(NUM_CENTERS) : 1
) (
	input  logic clk,
	input  logic rst,
	input  logic op_valid,
	input  kmeans_pkg::op_e op,
	input  logic [IDX_W-1:0] op_index,
	input  kmeans_pkg::point_t op_center,
	input  logic buf_empty,
	input  logic pipe_idle,
	input  logic mean_valid,
	input  logic [IDX_W-1:0] mean_index,
	input  kmeans_pkg::point_t mean,
	input  logic div_done,
	input  logic [IDX_W-1:0] read_index,
	output logic accept_points,
	output logic div_start,
	output logic clear_acc,
	output kmeans_pkg::point_t centers [NUM_CENTERS],
	output logic busy,
	output logic iter_done,
	output logic iter_stable,
	output kmeans_pkg::point_t read_center
);
	import kmeans_pkg::*;

	ctrl_state_e state;
	point_t means [NUM_CENTERS];
	logic all_stable;
	logic mean_stable;

	// strictly inside the tolerance band
	function automatic logic near(coord_t a, coord_t b);
		coord_t diff;
		diff = (a > b) ? a - b : b - a;
		return diff < THRESHOLD;
	endfunction

	// incoming mean against the center it replaces
	always_comb begin
		mean_stable = 1'b1;
		for (int d = 0; d < DIM; d++) begin
			if (!near(mean[d], centers[mean_index][d]))
				mean_stable = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			all_stable <= 1'b0;
			for (int i = 0; i < NUM_CENTERS; i++) begin
				centers[i] <= '0;
				means[i] <= '0;
			end
		end else begin
			case (state)
				// commands only taken while not busy
				st_idle: begin
					if (op_valid) begin
						case (op)
							op_load_center: centers[op_index] <= op_center;
							op_divide: state <= st_drain;
							op_new_iteration: state <= st_update;
							default: ;
						endcase
					end
				end
				// queued points still flow in until buffer and pipeline are empty
				st_drain: begin
					if (buf_empty && pipe_idle) begin
						all_stable <= 1'b1;
						state <= st_divide;
					end
				end
				st_divide: begin
					if (mean_valid) begin
						means[mean_index] <= mean;
						if (!mean_stable)
							all_stable <= 1'b0;
					end
					if (div_done)
						state <= st_idle;
				end
				// means become the centers, sums clear on the same edge
				st_update: begin
					for (int i = 0; i < NUM_CENTERS; i++)
						centers[i] <= means[i];
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// readback port, one cycle behind read_index
	always_ff @(posedge clk) begin
		read_center <= centers[read_index];
	end

	assign busy = (state != st_idle);
	assign accept_points = (state == st_idle) || (state == st_drain);
	assign div_start = (state == st_drain) && buf_empty && pipe_idle;
	assign clear_acc = (state == st_update);
	assign iter_done = (state == st_divide) && div_done;
	assign iter_stable = iter_done && all_stable;

endmodule

//--- source/kmeans_engine.sv
`timescale 1ns/100ps

module kmeans_engine #(
	parameter int NUM_CENTERS = 4,
	parameter int THRESHOLD = 2,
	parameter int CREDITS = 4,
	localparam int IDX_W = (NUM_CENTERS > 1) ? $clog2(NUM_CENTERS) : 1
) (
	input  logic clk,
	input  logic rst,
	input  logic point_valid,
	input  kmeans_pkg::point_t point,
	output logic point_credit,
	input  logic op_valid,
	input  kmeans_pkg::op_e op,
	input  logic [IDX_W-1:0] op_index,
	input  kmeans_pkg::point_t op_center,
	output logic busy,
	output logic assign_valid,
	output logic [IDX_W-1:0] assign_index,
	output logic iter_done,
	output logic iter_stable,
	input  logic [IDX_W-1:0] read_index,
	output kmeans_pkg::point_t read_center
);
	import kmeans_pkg::*;

	// buffer to pipeline
	logic pop_valid;
	point_t pop_point;
	logic buf_empty;
	logic accept_points;
	logic pipe_idle;

	// pipeline to accumulator
	point_t assign_point;

	// center array shared by pipeline, divider and controller
	point_t centers [NUM_CENTERS];

	// divide run
	logic div_start;
	logic clear_acc;
	logic mean_valid;
	logic [IDX_W-1:0] mean_index;
	point_t mean;
	logic div_done;

	centroid_if #(.NUM_CENTERS(NUM_CENTERS)) sums_if ();

	point_buffer #(.CREDITS(CREDITS)) point_buffer_i (
		.clk(clk),
		.rst(rst),
		.in_valid(point_valid),
		.in_point(point),
		.pop(accept_points),
		.out_valid(pop_valid),
		.out_point(pop_point),
		.empty(buf_empty),
		.credit(point_credit)
	);

	nearest_center #(.NUM_CENTERS(NUM_CENTERS)) nearest_center_i (
		.clk(clk),
		.rst(rst),
		.in_valid(pop_valid),
		.in_point(pop_point),
		.centers(centers),
		.out_valid(assign_valid),
		.out_index(assign_index),
		.out_point(assign_point),
		.idle(pipe_idle)
	);

	centroid_accumulator #(.NUM_CENTERS(NUM_CENTERS)) centroid_accumulator_i (
		.clk(clk),
		.rst(rst),
		.add_valid(assign_valid),
		.add_index(assign_index),
		.add_point(assign_point),
		.clear_acc(clear_acc),
		.rd(sums_if.acc)
	);

	centroid_divider #(.NUM_CENTERS(NUM_CENTERS)) centroid_divider_i (
		.clk(clk),
		.rst(rst),
		.div_start(div_start),
		.rd(sums_if.div),
		.old_centers(centers),
		.mean_valid(mean_valid),
		.mean_index(mean_index),
		.mean(mean),
		.div_done(div_done)
	);

	iteration_control #(
		.NUM_CENTERS(NUM_CENTERS),
		.THRESHOLD(THRESHOLD)
	) iteration_control_i (
		.clk(clk),
		.rst(rst),
		.op_valid(op_valid),
		.op(op),
		.op_index(op_index),
		.op_center(op_center),
		.buf_empty(buf_empty),
		.pipe_idle(pipe_idle),
		.mean_valid(mean_valid),
		.mean_index(mean_index),
		.mean(mean),
		.div_done(div_done),
		.read_index(read_index),
		.accept_points(accept_points),
		.div_start(div_start),
		.clear_acc(clear_acc),
		.centers(centers),
		.busy(busy),
		.iter_done(iter_done),
		.iter_stable(iter_stable),
		.read_center(read_center)
	);

endmodule

//--- verification/kmeans_engine_checker.sv
`timescale 1ns/100ps

module kmeans_engine_checker #(
	parameter int NUM_CENTERS = 4,
	parameter int CREDITS = 4,
	localparam int IDX_W = (NUM_CENTERS > 1) ? $clog2(NUM_CENTERS) : 1
) (
	input logic clk,
	input logic rst,
	input logic point_valid,
	input logic point_credit,
	input logic busy,
	input logic assign_valid,
	input logic [IDX_W-1:0] assign_index,
	input logic iter_done
);

	// points sent and not yet credited back
	int outstanding;

	// failed assertions so far
	int assert_failures = 0;

	always_ff @(posedge clk) begin
		if (rst)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(point_valid) - int'(point_credit);
	end

	// source never holds more points than the buffer depth
	credits_bounded: assert property (@(posedge clk) disable iff (rst)
		outstanding <= CREDITS)
		else begin
			assert_failures++;
			$error("more than %0d points outstanding", CREDITS);
		end

	index_in_range: assert property (@(posedge clk) disable iff (rst)
		assign_valid |-> (assign_index < NUM_CENTERS))
		else begin
			assert_failures++;
			$error("assign_index out of range");
		end

	// divide run ends while busy and frees the engine one cycle later
	done_while_busy: assert property (@(posedge clk) disable iff (rst)
		iter_done |-> busy ##1 !busy)
		else begin
			assert_failures++;
			$error("iter_done outside busy or busy not released after it");
		end

	idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !busy)
		else begin
			assert_failures++;
			$error("busy high in the first cycle after reset");
		end

endmodule

//--- verification/kmeans_engine_tb.sv
`timescale 1ns/100ps

module kmeans_engine_tb;
	import kmeans_pkg::*;

	localparam int NUM_CENTERS = 4;
	localparam int THRESHOLD = 2;
	localparam int CREDITS = 4;
	localparam int IDX_W = (NUM_CENTERS > 1) ? $clog2(NUM_CENTERS) : 1;
	localparam int NUM_POINTS = 24;
	localparam int MAX_ITERS = 8;
	// every center with points: load and shifts per coordinate, one emit
	localparam int DIVIDE_CYCLES = NUM_CENTERS * (DIM * (ACC_W + 1) + 1) + 2;
	// one iteration, points plus burst at a few cycles each, a divide and commands
	localparam int ITER_CYCLES = (NUM_POINTS + CREDITS) * 8 + DIVIDE_CYCLES + 20;
	localparam int LIMIT_CYCLES = (MAX_ITERS + 4) * ITER_CYCLES + 200;

	logic clk;
	logic rst;
	logic point_valid;
	point_t point;
	logic point_credit;
	logic op_valid;
	op_e op;
	logic [IDX_W-1:0] op_index;
	point_t op_center;
	logic busy;
	logic assign_valid;
	logic [IDX_W-1:0] assign_index;
	logic iter_done;
	logic iter_stable;
	logic [IDX_W-1:0] read_index;
	point_t read_center;

	// reference model
	point_t model_centers [NUM_CENTERS];
	point_t model_means [NUM_CENTERS];
	int model_sums [NUM_CENTERS][DIM];
	int model_counts [NUM_CENTERS];
	point_t pts [NUM_POINTS];
	point_t bases [3];
	int exp_index [$];

	// source credits and divide observations
	int avail;
	int avail_at_done;
	int busy_credits;
	logic done_seen;
	logic stable_seen;
	logic converged;

	string test_name;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	kmeans_engine #(
		.NUM_CENTERS(NUM_CENTERS),
		.THRESHOLD(THRESHOLD),
		.CREDITS(CREDITS)
	) kmeans_engine_i (
		.clk(clk),
		.rst(rst),
		.point_valid(point_valid),
		.point(point),
		.point_credit(point_credit),
		.op_valid(op_valid),
		.op(op),
		.op_index(op_index),
		.op_center(op_center),
		.busy(busy),
		.assign_valid(assign_valid),
		.assign_index(assign_index),
		.iter_done(iter_done),
		.iter_stable(iter_stable),
		.read_index(read_index),
		.read_center(read_center)
	);

	bind kmeans_engine kmeans_engine_checker #(
		.NUM_CENTERS(NUM_CENTERS),
		.CREDITS(CREDITS)
	) kmeans_engine_checker_i (
		.clk(clk),
		.rst(rst),
		.point_valid(point_valid),
		.point_credit(point_credit),
		.busy(busy),
		.assign_valid(assign_valid),
		.assign_index(assign_index),
		.iter_done(iter_done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// hard stop if a handshake never comes
	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic compare(string what, int expected, int actual);
		if (expected != actual) begin
			$display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, test_errors);
		end
	endtask

	// random point within 15 of a cluster base
	function automatic point_t near_point(point_t b);
		point_t p;
		for (int k = 0; k < DIM; k++)
			p[k] = b[k] + coord_t'($urandom_range(15));
		return p;
	endfunction

	// smallest squared distance, lower index wins a tie
	function automatic int nearest(point_t p);
		int best;
		int best_d;
		int d;
		int diff;
		best = 0;
		best_d = -1;
		for (int i = 0; i < NUM_CENTERS; i++) begin
			d = 0;
			for (int k = 0; k < DIM; k++) begin
				diff = int'(p[k]) - int'(model_centers[i][k]);
				d += diff * diff;
			end
			if (best_d < 0 || d < best_d) begin
				best = i;
				best_d = d;
			end
		end
		return best;
	endfunction

	// output side, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (point_credit) begin
				avail++;
				if (busy)
					busy_credits++;
			end
			if (assign_valid) begin
				if (exp_index.size() == 0) begin
					$display("assignment arrived with no point outstanding in %s", test_name);
					errors++;
					test_errors++;
				end else begin
					compare("assign_index", exp_index.pop_front(), int'(assign_index));
				end
			end
			if (iter_done) begin
				done_seen = 1'b1;
				stable_seen = iter_stable;
				avail_at_done = avail;
			end
		end
	end

	// one point per cycle while credits last, model assigns it right away
	task automatic send_point(point_t p);
		int idx;
		@(posedge clk);
		while (avail == 0) begin
			point_valid <= 1'b0;
			@(posedge clk);
		end
		point_valid <= 1'b1;
		point <= p;
		avail--;
		idx = nearest(p);
		exp_index.push_back(idx);
		model_counts[idx]++;
		for (int k = 0; k < DIM; k++)
			model_sums[idx][k] += int'(p[k]);
	endtask

	task automatic stop_points();
		@(posedge clk);
		point_valid <= 1'b0;
	endtask

	// all assignments seen and all credits home
	task automatic wait_drained();
		@(negedge clk);
		while (exp_index.size() != 0 || avail != CREDITS)
			@(negedge clk);
	endtask

	task automatic send_all();
		for (int j = 0; j < NUM_POINTS; j++)
			send_point(pts[j]);
		stop_points();
		wait_drained();
	endtask

	// single-cycle request once busy is low
	task automatic send_cmd(op_e o, int idx, point_t c);
		@(negedge clk);
		while (busy)
			@(negedge clk);
		@(posedge clk);
		op_valid <= 1'b1;
		op <= o;
		op_index <= idx[IDX_W-1:0];
		op_center <= c;
		@(posedge clk);
		op_valid <= 1'b0;
	endtask

	// read_center lags read_index by one edge
	task automatic read_check(int idx, point_t expected);
		@(posedge clk);
		read_index <= idx[IDX_W-1:0];
		@(posedge clk);
		@(negedge clk);
		compare($sformatf("center %0d", idx), int'(expected), int'(read_center));
	endtask

	task automatic model_divide(output logic stable);
		int m;
		int diff;
		stable = 1'b1;
		for (int i = 0; i < NUM_CENTERS; i++) begin
			for (int k = 0; k < DIM; k++) begin
				// floor mean, empty cluster keeps its center
				if (model_counts[i] == 0)
					m = int'(model_centers[i][k]);
				else
					m = model_sums[i][k] / model_counts[i];
				model_means[i][k] = coord_t'(m);
				diff = m - int'(model_centers[i][k]);
				if (diff < 0)
					diff = -diff;
				if (diff >= THRESHOLD)
					stable = 1'b0;
			end
		end
	endtask

	task automatic model_new_iteration();
		for (int i = 0; i < NUM_CENTERS; i++) begin
			model_centers[i] = model_means[i];
			model_counts[i] = 0;
			for (int k = 0; k < DIM; k++)
				model_sums[i][k] = 0;
		end
	endtask

	// divide run, optionally with a burst of points held back while busy
	task automatic run_divide(int burst);
		logic expected;
		done_seen = 1'b0;
		busy_credits = 0;
		send_cmd(op_divide, 0, '0);
		model_divide(expected);
		if (burst > 0) begin
			@(negedge clk);
			while (!busy)
				@(negedge clk);
			for (int j = 0; j < burst; j++)
				send_point(near_point(bases[j % 3]));
			stop_points();
		end
		while (!done_seen)
			@(negedge clk);
		compare("iter_stable", int'(expected), int'(stable_seen));
		if (burst > 0) begin
			compare("credits left at done", 0, avail_at_done);
			compare("credits during divide", 0, busy_credits);
			wait_drained();
		end
	endtask

	initial begin
		point_t c;
		int asserts;
		rst = 1'b1;
		point_valid = 1'b0;
		point = '0;
		op_valid = 1'b0;
		op = op_nop;
		op_index = '0;
		op_center = '0;
		read_index = '0;
		avail = CREDITS;
		avail_at_done = 0;
		busy_credits = 0;
		done_seen = 1'b0;
		stable_seen = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(32'ha2ce));
		// cluster bases, {z, y, x}
		bases[0] = {8'd16, 8'd16, 8'd16};
		bases[1] = {8'd56, 8'd24, 8'd96};
		bases[2] = {8'd88, 8'd100, 8'd32};
		for (int i = 0; i < NUM_CENTERS; i++)
			model_means[i] = '0;
		model_new_iteration();
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// last center sits far from every point
		begin_test("load_readback");
		for (int i = 0; i < NUM_CENTERS; i++) begin
			c = (i < 3) ? near_point(bases[i]) : point_t'({3{8'd250}});
			send_cmd(op_load_center, i, c);
			model_centers[i] = c;
		end
		for (int i = 0; i < NUM_CENTERS; i++)
			read_check(i, model_centers[i]);
		end_test();

		begin_test("assign_order");
		for (int j = 0; j < NUM_POINTS; j++)
			pts[j] = near_point(bases[j % 3]);
		send_all();
		end_test();

		begin_test("credit_burst");
		run_divide(CREDITS);
		end_test();

		begin_test("means_readback");
		send_cmd(op_new_iteration, 0, '0);
		model_new_iteration();
		for (int i = 0; i < NUM_CENTERS; i++)
			read_check(i, model_centers[i]);
		read_check(NUM_CENTERS - 1, point_t'({3{8'd250}}));
		end_test();

		// same points until the centers settle
		begin_test("stability");
		converged = 1'b0;
		for (int it = 0; it < MAX_ITERS && !converged; it++) begin
			send_all();
			run_divide(0);
			send_cmd(op_new_iteration, 0, '0);
			model_new_iteration();
			converged = stable_seen;
		end
		compare("converged", 1, int'(converged));
		// far point joins the empty cluster and drags it
		pts[0] = {3{8'd200}};
		send_all();
		run_divide(0);
		compare("moved point", 0, int'(stable_seen));
		end_test();

		asserts = kmeans_engine_i.kmeans_engine_checker_i.assert_failures;
		$display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_failed, errors, asserts);
		if (errors == 0 && tests_failed == 0 && asserts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
source/kmeans_pkg.sv
source/centroid_if.sv
source/point_buffer.sv
source/nearest_center.sv
source/centroid_accumulator.sv
source/centroid_divider.sv
source/iteration_control.sv
source/kmeans_engine.sv
verification/kmeans_engine_checker.sv
verification/kmeans_engine_tb.sv

//--- run.sh
#!/bin/sh
# build and run the k-means engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module kmeans_engine_tb \
	-f build.f \
	--Mdir obj_dir \
	-o kmeans_sim

./obj_dir/kmeans_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
